//--- Bender.yml
package:
  name: rv_decoder

sources:
  - src/isa_pkg.sv
  - src/ctrl_pkg.sv
  - src/base_decoder.sv
  - src/muldiv_decoder.sv
  - src/ctrl_merge.sv
  - src/rv_decoder.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/rv_decoder_tb.sv

//--- dv/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

task automatic build_vectors();
   // Instruction word, valid strobe and expected bundle per entry
   // alu_expect args: alu_op, reg_wr_en, wb_sel, op1_sel, op2_sel, is_load, is_store

   // Register forms, rd x3, rs1 x1, rs2 x2
   add_vector(32'h002081B3, 1'b1, alu_expect(ALU_ADD, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h402081B3, 1'b1, alu_expect(ALU_SUB, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h002091B3, 1'b1, alu_expect(ALU_SLL, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h0020A1B3, 1'b1, alu_expect(ALU_SLT, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h0020B1B3, 1'b1, alu_expect(ALU_SLTU, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h0020C1B3, 1'b1, alu_expect(ALU_XOR, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h0020D1B3, 1'b1, alu_expect(ALU_SRL, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h4020D1B3, 1'b1, alu_expect(ALU_SRA, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h0020E1B3, 1'b1, alu_expect(ALU_OR, 1, WB_EXE, 0, 0, 0, 0));
   add_vector(32'h0020F1B3, 1'b1, alu_expect(ALU_AND, 1, WB_EXE, 0, 0, 0, 0));

   // Immediate forms, imm 5
   add_vector(32'h00508193, 1'b1, alu_expect(ALU_ADD, 1, WB_EXE, 0, 1, 0, 0));
   add_vector(32'h00509193, 1'b1, alu_expect(ALU_SLL, 1, WB_EXE, 0, 1, 0, 0));
   add_vector(32'h0050A193, 1'b1, alu_expect(ALU_SLT, 1, WB_EXE, 0, 1, 0, 0));
   add_vector(32'h0050B193, 1'b1, alu_expect(ALU_SLTU, 1, WB_EXE, 0, 1, 0, 0));
   add_vector(32'h0050C193, 1'b1, alu_expect(ALU_XOR, 1, WB_EXE, 0, 1, 0, 0));
   add_vector(32'h0050D193, 1'b1, alu_expect(ALU_SRL, 1, WB_EXE, 0, 1, 0, 0));
   add_vector(32'h4050D193, 1'b1, alu_expect(ALU_SRA, 1, WB_EXE, 0, 1, 0, 0));
   add_vector(32'h0050E193, 1'b1, alu_expect(ALU_OR, 1, WB_EXE, 0, 1, 0, 0));
   add_vector(32'h0050F193, 1'b1, alu_expect(ALU_AND, 1, WB_EXE, 0, 1, 0, 0));

   // LW, SW, BEQ, JAL, JALR, LUI
   add_vector(32'h0040A183, 1'b1, alu_expect(ALU_ADD, 1, WB_LOAD, 0, 1, 1, 0));
   add_vector(32'h0020A423, 1'b1, alu_expect(ALU_ADD, 0, WB_EXE, 0, 1, 0, 1));
   add_vector(32'h00208463, 1'b1, alu_expect(ALU_ADD, 0, WB_EXE, 1, 1, 0, 0));
   add_vector(32'h010000EF, 1'b1, alu_expect(ALU_ADD, 1, WB_PC4, 1, 1, 0, 0));
   add_vector(32'h000100E7, 1'b1, alu_expect(ALU_ADD, 1, WB_PC4, 0, 1, 0, 0));
   add_vector(32'h123451B7, 1'b1, alu_expect(ALU_LUI, 1, WB_EXE, 0, 1, 0, 0));
   // Two idle cycles, ctrl_o must keep the LUI bundle
   add_vector(32'h00100073, 1'b0, '0);
   add_vector(32'h402081B3, 1'b0, '0);
   add_vector(32'h00001197, 1'b1, alu_expect(ALU_ADD, 1, WB_EXE, 1, 1, 0, 0));

   // MUL through REMU
   add_vector(32'h022081B3, 1'b1, mdu_expect(3'b000));
   add_vector(32'h022091B3, 1'b1, mdu_expect(3'b001));
   add_vector(32'h0220A1B3, 1'b1, mdu_expect(3'b010));
   add_vector(32'h0220B1B3, 1'b1, mdu_expect(3'b011));
   add_vector(32'h0220C1B3, 1'b1, mdu_expect(3'b100));
   add_vector(32'h0220D1B3, 1'b1, mdu_expect(3'b101));
   add_vector(32'h0220E1B3, 1'b1, mdu_expect(3'b110));
   add_vector(32'h0220F1B3, 1'b1, mdu_expect(3'b111));

   // ECALL, EBREAK, then custom-0, funct7 0010000, CLZ, CSRRW, MRET
   add_vector(32'h00000073, 1'b1, trap_expect(EXC_ECALL));
   add_vector(32'h00100073, 1'b1, trap_expect(EXC_EBREAK));
   add_vector(32'h0000000B, 1'b1, trap_expect(EXC_ILLEGAL));
   add_vector(32'h202081B3, 1'b1, trap_expect(EXC_ILLEGAL));
   add_vector(32'h60009193, 1'b1, trap_expect(EXC_ILLEGAL));
   add_vector(32'h300091F3, 1'b1, trap_expect(EXC_ILLEGAL));
   add_vector(32'h30200073, 1'b1, trap_expect(EXC_ILLEGAL));
endtask

`endif

//--- dv/rv_decoder_tb.sv
`timescale 1ns/1ps

module rv_decoder_tb;

   import ctrl_pkg::*;

   localparam int CLK_PERIOD = 20;

   typedef struct packed {
      logic [31:0]  word;
      logic         valid;
      decode_ctrl_t ctrl;
   } vector_t;

   logic            clk;
   logic            rst_n;
   isa_pkg::instr_t instr;
   logic            instr_valid;
   decode_ctrl_t    ctrl;
   logic            ctrl_valid;

   vector_t      vectors[$];
   decode_ctrl_t exp_ctrl;
   int           errors;

   rv_decoder rv_decoder_i (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .instr_i       (instr),
      .instr_valid_i (instr_valid),
      .ctrl_o        (ctrl),
      .ctrl_valid_o  (ctrl_valid)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %0t ns %s actual %h expected %h", $time, name, actual, expected);
      end
   endtask

   // Bundle of an ALU class with exc left at none
   function automatic decode_ctrl_t alu_expect(input alu_op_t op, input logic wr,
                                               input wb_sel_t wb, input logic op1,
                                               input logic op2, input logic ld,
                                               input logic st);
      decode_ctrl_t c;
      c           = '0;
      c.unit_sel  = UNIT_ALU;
      c.alu_op    = op;
      c.reg_wr_en = wr;
      c.wb_sel    = wb;
      c.op1_sel   = op1;
      c.op2_sel   = op2;
      c.is_load   = ld;
      c.is_store  = st;
      return c;
   endfunction

   function automatic decode_ctrl_t mdu_expect(input mdu_op_t op);
      decode_ctrl_t c;
      c           = '0;
      c.unit_sel  = UNIT_MDU;
      c.mdu_en    = 1'b1;
      c.mdu_op    = op;
      c.reg_wr_en = 1'b1;
      return c;
   endfunction

   // Exceptions and illegal words carry only the exc code
   function automatic decode_ctrl_t trap_expect(input exc_t code);
      decode_ctrl_t c;
      c     = '0;
      c.exc = code;
      return c;
   endfunction

   task automatic add_vector(input logic [31:0] word, input logic valid, input decode_ctrl_t c);
      vector_t v;
      v.word  = word;
      v.valid = valid;
      v.ctrl  = c;
      vectors.push_back(v);
   endtask

   // Idle entries expect the last loaded bundle
   task automatic check_entry(input vector_t v);
      if (v.valid) begin
         exp_ctrl = v.ctrl;
      end
      compare_value("ctrl_valid_o", ctrl_valid, v.valid);
      compare_value("ctrl_o", ctrl, exp_ctrl);
   endtask

   `include "decode_vectors.svh"

   initial begin
      // Table is complete before the first clock edge
      @(posedge clk);
      #((vectors.size() + 20) * CLK_PERIOD);
      $display("Timeout, decoder results did not arrive within the expected number of cycles");
      $display("Test failed");
      $finish;
   end

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      errors   = 0;
      exp_ctrl = '0;
      // Word zero decodes as a load and reset has to block its strobe
      instr       = '0;
      instr_valid = 1'b1;
      build_vectors();

      repeat (3) @(posedge clk);
      rst_n       <= 1'b1;
      instr_valid <= 1'b0;
      @(negedge clk);
      compare_value("ctrl_valid_o", ctrl_valid, 32'h0);
      compare_value("ctrl_o", ctrl, 32'h0);

      // Drive entry i while entry i-1 comes out of the stage register
      for (int i = 0; i <= vectors.size(); i++) begin
         @(posedge clk);
         if (i < vectors.size()) begin
            instr       <= vectors[i].word[31:2];
            instr_valid <= vectors[i].valid;
         end else begin
            instr_valid <= 1'b0;
         end
         if (i > 0) begin
            @(negedge clk);
            check_entry(vectors[i - 1]);
         end
      end

      $display("Decode checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- rv_decoder.f
+incdir+dv
src/isa_pkg.sv
src/ctrl_pkg.sv
src/base_decoder.sv
src/muldiv_decoder.sv
src/ctrl_merge.sv
src/rv_decoder.sv
dv/rv_decoder_tb.sv

//--- src/base_decoder.sv
`timescale 1ns/1ps

module base_decoder (
   input  isa_pkg::instr_t        instr_i,
   output ctrl_pkg::decode_ctrl_t base_ctrl_o
);

   import isa_pkg::*;
   import ctrl_pkg::*;

   opcode_t  opcode;
   funct3_t  funct3;
   funct7_t  funct7;
   funct12_t funct12;
   reg_idx_t rd;
   reg_idx_t rs1;

   assign opcode  = instr_i[6:2];
   assign rd      = instr_i[11:7];
   assign funct3  = instr_i[14:12];
   assign rs1     = instr_i[19:15];
   assign funct7  = instr_i[31:25];
   assign funct12 = instr_i[31:20];

   // Common ALU bundle with the memory flags left clear
   function automatic decode_ctrl_t alu_ctrl(
      input alu_op_t op,
      input logic    wr_en,
      input wb_sel_t wb,
      input logic    op1,
      input logic    op2
   );
      decode_ctrl_t c;
      c           = '0;
      c.unit_sel  = UNIT_ALU;
      c.exc       = EXC_NONE;
      c.alu_op    = op;
      c.reg_wr_en = wr_en;
      c.wb_sel    = wb;
      c.op1_sel   = op1;
      c.op2_sel   = op2;
      return c;
   endfunction

   function automatic decode_ctrl_t reg_op(input alu_op_t op);
      return alu_ctrl(op, 1'b1, WB_EXE, 1'b0, 1'b0);
   endfunction

   function automatic decode_ctrl_t imm_op(input alu_op_t op);
      return alu_ctrl(op, 1'b1, WB_EXE, 1'b0, 1'b1);
   endfunction

   always_comb begin
      base_ctrl_o = CTRL_ILLEGAL;
      case (opcode)
         OPC_LOAD: begin
            base_ctrl_o         = alu_ctrl(ALU_ADD, 1'b1, WB_LOAD, 1'b0, 1'b1);
            base_ctrl_o.is_load = 1'b1;
         end
         OPC_STORE: begin
            base_ctrl_o          = alu_ctrl(ALU_ADD, 1'b0, WB_EXE, 1'b0, 1'b1);
            base_ctrl_o.is_store = 1'b1;
         end
         // Target address computed from PC and offset
         OPC_BRANCH: base_ctrl_o = alu_ctrl(ALU_ADD, 1'b0, WB_EXE, 1'b1, 1'b1);
         OPC_AUIPC:  base_ctrl_o = alu_ctrl(ALU_ADD, 1'b1, WB_EXE, 1'b1, 1'b1);
         OPC_JAL:    base_ctrl_o = alu_ctrl(ALU_ADD, 1'b1, WB_PC4, 1'b1, 1'b1);
         OPC_JALR:   base_ctrl_o = alu_ctrl(ALU_ADD, 1'b1, WB_PC4, 1'b0, 1'b1);
         OPC_LUI:    base_ctrl_o = imm_op(ALU_LUI);
         OPC_ITYPE: begin
            case (funct3)
               F3_ADD_SUB: base_ctrl_o = imm_op(ALU_ADD);
               F3_SLT:     base_ctrl_o = imm_op(ALU_SLT);
               F3_SLTU:    base_ctrl_o = imm_op(ALU_SLTU);
               F3_XOR:     base_ctrl_o = imm_op(ALU_XOR);
               F3_OR:      base_ctrl_o = imm_op(ALU_OR);
               F3_AND:     base_ctrl_o = imm_op(ALU_AND);
               // Upper immediate bits of a shift must be a valid funct7
               F3_SLL: begin
                  if (funct7 == F7_BASE) begin
                     base_ctrl_o = imm_op(ALU_SLL);
                  end
               end
               F3_SRL_SRA: begin
                  if (funct7 == F7_BASE) begin
                     base_ctrl_o = imm_op(ALU_SRL);
                  end else if (funct7 == F7_ALT) begin
                     base_ctrl_o = imm_op(ALU_SRA);
                  end
               end
            endcase
         end
         OPC_RTYPE: begin
            case (funct7)
               F7_BASE: begin
                  case (funct3)
                     F3_ADD_SUB: base_ctrl_o = reg_op(ALU_ADD);
                     F3_SLL:     base_ctrl_o = reg_op(ALU_SLL);
                     F3_SLT:     base_ctrl_o = reg_op(ALU_SLT);
                     F3_SLTU:    base_ctrl_o = reg_op(ALU_SLTU);
                     F3_XOR:     base_ctrl_o = reg_op(ALU_XOR);
                     F3_SRL_SRA: base_ctrl_o = reg_op(ALU_SRL);
                     F3_OR:      base_ctrl_o = reg_op(ALU_OR);
                     F3_AND:     base_ctrl_o = reg_op(ALU_AND);
                  endcase
               end
               F7_ALT: begin
                  case (funct3)
                     F3_ADD_SUB: base_ctrl_o = reg_op(ALU_SUB);
                     F3_SRL_SRA: base_ctrl_o = reg_op(ALU_SRA);
                     default:    base_ctrl_o = CTRL_ILLEGAL;
                  endcase
               end
               // M encodings belong to the MDU decoder
               default: base_ctrl_o = CTRL_ILLEGAL;
            endcase
         end
         OPC_SYSTEM: begin
            if (funct3 == F3_PRIV && rd == '0 && rs1 == '0) begin
               case (funct12)
                  F12_ECALL: begin
                     base_ctrl_o     = '0;
                     base_ctrl_o.exc = EXC_ECALL;
                  end
                  F12_EBREAK: begin
                     base_ctrl_o     = '0;
                     base_ctrl_o.exc = EXC_EBREAK;
                  end
                  default: base_ctrl_o = CTRL_ILLEGAL;
               endcase
            end
         end
         default: base_ctrl_o = CTRL_ILLEGAL;
      endcase
   end

endmodule

//--- src/ctrl_merge.sv
`timescale 1ns/1ps

module ctrl_merge (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   valid_i,
   input  ctrl_pkg::decode_ctrl_t base_ctrl_i,
   input  ctrl_pkg::decode_ctrl_t mdu_ctrl_i,
   input  logic                   mdu_hit_i,
   output ctrl_pkg::decode_ctrl_t ctrl_o,
   output logic                   ctrl_valid_o
);

   import ctrl_pkg::*;

   decode_ctrl_t sel_ctrl;

   assign sel_ctrl = mdu_hit_i ? mdu_ctrl_i : base_ctrl_i;

   // Stage register that holds the last bundle between strobes
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_o       <= '0;
         ctrl_valid_o <= 1'b0;
      end else begin
         ctrl_valid_o <= valid_i;
         if (valid_i) begin
            ctrl_o <= sel_ctrl;
         end
      end
   end

   // Base decoder must reject every word the MDU decoder claims
   mdu_hit_excl_a: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (valid_i && mdu_hit_i) |-> (base_ctrl_i == CTRL_ILLEGAL)
   ) else $error("M encoding also decoded by base decoder: %h", base_ctrl_i);

endmodule

//--- src/ctrl_pkg.sv
package ctrl_pkg;

   typedef logic [1:0] unit_sel_t;
   typedef logic [1:0] exc_t;
   typedef logic [3:0] alu_op_t;
   typedef logic [2:0] mdu_op_t;
   typedef logic [1:0] wb_sel_t;

   localparam unit_sel_t UNIT_ALU = 2'b00;
   localparam unit_sel_t UNIT_MDU = 2'b01;

   localparam exc_t EXC_NONE    = 2'b00;
   localparam exc_t EXC_ILLEGAL = 2'b01;
   localparam exc_t EXC_ECALL   = 2'b10;
   localparam exc_t EXC_EBREAK  = 2'b11;

   localparam alu_op_t ALU_ADD  = 4'b0000;
   localparam alu_op_t ALU_SUB  = 4'b0001;
   localparam alu_op_t ALU_SLL  = 4'b0011;
   localparam alu_op_t ALU_SLT  = 4'b0100;
   localparam alu_op_t ALU_SLTU = 4'b0101;
   localparam alu_op_t ALU_XOR  = 4'b0110;
   localparam alu_op_t ALU_SRL  = 4'b0111;
   localparam alu_op_t ALU_SRA  = 4'b1000;
   localparam alu_op_t ALU_OR   = 4'b1001;
   localparam alu_op_t ALU_AND  = 4'b1010;
   localparam alu_op_t ALU_LUI  = 4'b1100;

   // Write-back source, 10 is unused
   localparam wb_sel_t WB_EXE  = 2'b00;
   localparam wb_sel_t WB_LOAD = 2'b01;
   localparam wb_sel_t WB_PC4  = 2'b11;

   // 19 bits, field order fixed for the execute stage
   typedef struct packed {
      unit_sel_t unit_sel;
      exc_t      exc;
      alu_op_t   alu_op;
      logic      mdu_en;
      mdu_op_t   mdu_op;
      logic      reg_wr_en;
      wb_sel_t   wb_sel;
      logic      op1_sel;   // 1 selects PC
      logic      op2_sel;   // 1 selects immediate
      logic      is_load;
      logic      is_store;
   } decode_ctrl_t;

   localparam decode_ctrl_t CTRL_ILLEGAL = '{exc: EXC_ILLEGAL, default: '0};

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

   // Instruction word without the two compressed-format bits
   typedef logic [31:2] instr_t;

   typedef logic [4:0]  opcode_t;
   typedef logic [2:0]  funct3_t;
   typedef logic [6:0]  funct7_t;
   typedef logic [11:0] funct12_t;
   typedef logic [4:0]  reg_idx_t;

   // Major opcodes, bits 6:2
   localparam opcode_t OPC_LOAD   = 5'b00000;
   localparam opcode_t OPC_ITYPE  = 5'b00100;
   localparam opcode_t OPC_AUIPC  = 5'b00101;
   localparam opcode_t OPC_STORE  = 5'b01000;
   localparam opcode_t OPC_RTYPE  = 5'b01100;
   localparam opcode_t OPC_LUI    = 5'b01101;
   localparam opcode_t OPC_BRANCH = 5'b11000;
   localparam opcode_t OPC_JALR   = 5'b11001;
   localparam opcode_t OPC_JAL    = 5'b11011;
   localparam opcode_t OPC_SYSTEM = 5'b11100;

   localparam funct7_t F7_BASE   = 7'b0000000;
   localparam funct7_t F7_ALT    = 7'b0100000;
   localparam funct7_t F7_MULDIV = 7'b0000001;

   // Shared by the register and immediate forms
   localparam funct3_t F3_ADD_SUB = 3'b000;
   localparam funct3_t F3_SLL     = 3'b001;
   localparam funct3_t F3_SLT     = 3'b010;
   localparam funct3_t F3_SLTU    = 3'b011;
   localparam funct3_t F3_XOR     = 3'b100;
   localparam funct3_t F3_SRL_SRA = 3'b101;
   localparam funct3_t F3_OR      = 3'b110;
   localparam funct3_t F3_AND     = 3'b111;

   // ECALL, EBREAK and the other privileged forms
   localparam funct3_t F3_PRIV = 3'b000;

   localparam funct12_t F12_ECALL  = 12'b0000000_00000;
   localparam funct12_t F12_EBREAK = 12'b0000000_00001;

endpackage

//--- src/muldiv_decoder.sv
`timescale 1ns/1ps

module muldiv_decoder #(
   parameter bit MulDivEn = 1'b1
) (
   input  isa_pkg::instr_t        instr_i,
   output ctrl_pkg::decode_ctrl_t mdu_ctrl_o,
   output logic                   mdu_hit_o
);

   import isa_pkg::*;
   import ctrl_pkg::*;

   opcode_t opcode;
   funct3_t funct3;
   funct7_t funct7;

   assign opcode = instr_i[6:2];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // Without the M extension these words fall through as illegal
   assign mdu_hit_o = MulDivEn && (opcode == OPC_RTYPE) && (funct7 == F7_MULDIV);

   // funct3 already names the MDU operation
   always_comb begin
      mdu_ctrl_o           = '0;
      mdu_ctrl_o.unit_sel  = UNIT_MDU;
      mdu_ctrl_o.mdu_en    = 1'b1;
      mdu_ctrl_o.mdu_op    = funct3;
      mdu_ctrl_o.reg_wr_en = 1'b1;
      mdu_ctrl_o.wb_sel    = WB_EXE;
   end

endmodule

//--- src/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder #(
   parameter bit MulDivEn = 1'b1
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  isa_pkg::instr_t        instr_i,
   input  logic                   instr_valid_i,
   output ctrl_pkg::decode_ctrl_t ctrl_o,
   output logic                   ctrl_valid_o
);

   import ctrl_pkg::*;

   decode_ctrl_t base_ctrl;
   decode_ctrl_t mdu_ctrl;
   logic         mdu_hit;

   base_decoder base_decoder_i (
      .instr_i     (instr_i),
      .base_ctrl_o (base_ctrl)
   );

   muldiv_decoder #(
      .MulDivEn (MulDivEn)
   ) muldiv_decoder_i (
      .instr_i    (instr_i),
      .mdu_ctrl_o (mdu_ctrl),
      .mdu_hit_o  (mdu_hit)
   );

   ctrl_merge ctrl_merge_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .valid_i      (instr_valid_i),
      .base_ctrl_i  (base_ctrl),
      .mdu_ctrl_i   (mdu_ctrl),
      .mdu_hit_i    (mdu_hit),
      .ctrl_o       (ctrl_o),
      .ctrl_valid_o (ctrl_valid_o)
   );

endmodule
